//--- verilog/ros2_shell_pkg.sv
`default_nettype none

package ros2_shell_pkg;

    localparam int RX_HDR_BYTES = 20;
    localparam int TX_HDR_BYTES = 13;

    // Received IPv4 header as delivered by the IP stack.
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_rx_hdr_t;

    // Byte 0 sits at the most significant end of the header.
    typedef union packed {
        ip_rx_hdr_t                        hdr;
        logic [0:RX_HDR_BYTES-1][7:0]      bytes;
    } ip_rx_hdr_u;

    // Transmit header fields taken by the IP stack.
    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_tx_hdr_t;

    typedef union packed {
        ip_tx_hdr_t                        hdr;
        logic [0:TX_HDR_BYTES-1][7:0]      bytes;
    } ip_tx_hdr_u;

    typedef struct packed {
        logic [7:0] tdata;
        logic       tlast;
    } ip_beat_t;

    typedef enum logic [1:0] {
        GRANT_NONE = 2'b00,
        GRANT_IP   = 2'b01,
        GRANT_CPU  = 2'b10
    } app_grant_e;

endpackage

`default_nettype wire

//--- verilog/byte_fifo.sv
`default_nettype none

module byte_fifo #(
    parameter int DEPTH = 64
) (
    input  logic       clk_int,
    input  logic       rst_int,
    input  logic       wr_en,
    input  logic [7:0] din,
    input  logic       rd_en,
    output logic [7:0] dout,
    output logic       full,
    output logic       empty
);

    localparam int AW = $clog2(DEPTH);

    logic [7:0]  mem [0:DEPTH-1];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    if ((DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
        $error("byte_fifo DEPTH must be a power of two");
    end

    // The extra pointer bit tells a full buffer from an empty one.
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign dout  = mem[rd_ptr[AW-1:0]]; // Head byte is visible without a read.

    always_ff @(posedge clk_int) begin
        if (wr_en && !full) begin
            mem[wr_ptr[AW-1:0]] <= din;
        end
    end

    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    a_no_write_when_full: assert property (
        @(posedge clk_int) disable iff (rst_int) !(wr_en && full)
    ) else $error("byte_fifo written while full");

    a_no_read_when_empty: assert property (
        @(posedge clk_int) disable iff (rst_int) !(rd_en && empty)
    ) else $error("byte_fifo read while empty");

endmodule

`default_nettype wire

//--- verilog/ip_rx_framer.sv
`default_nettype none

module ip_rx_framer (
    input  logic                     clk_int,
    input  logic                     rst_int,
    input  logic                     hdr_valid,
    output logic                     hdr_ready,
    input  ros2_shell_pkg::ip_rx_hdr_t hdr,
    input  logic                     payload_valid,
    output logic                     payload_ready,
    input  ros2_shell_pkg::ip_beat_t payload,
    input  logic                     fifo_full,
    output logic                     fifo_wr_en,
    output logic [7:0]               fifo_din
);

    import ros2_shell_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_HEADER,
        RX_PAYLOAD
    } rx_state_e;

    rx_state_e  state;
    ip_rx_hdr_u hdr_buf;
    logic [4:0] byte_cnt;

    always_comb begin
        payload_ready = 1'b0;
        fifo_wr_en    = 1'b0;
        fifo_din      = payload.tdata;
        case (state)
            RX_HEADER: begin
                fifo_wr_en = !fifo_full;
                fifo_din   = hdr_buf.bytes[byte_cnt];
            end
            RX_PAYLOAD: begin
                payload_ready = !fifo_full;
                fifo_wr_en    = payload_valid && !fifo_full;
            end
            default: begin
                fifo_wr_en = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_int) begin
        if (hdr_valid && hdr_ready) begin
            hdr_buf.hdr <= hdr;
        end
    end

    // hdr_ready is registered so it comes up one cycle after reset.
    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            state     <= RX_IDLE;
            hdr_ready <= 1'b0;
            byte_cnt  <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (hdr_valid && hdr_ready) begin
                        state     <= RX_HEADER;
                        hdr_ready <= 1'b0;
                        byte_cnt  <= '0;
                    end else begin
                        hdr_ready <= 1'b1;
                    end
                end
                RX_HEADER: begin
                    if (!fifo_full) begin
                        if (byte_cnt == 5'(RX_HDR_BYTES - 1)) begin
                            state <= RX_PAYLOAD;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                RX_PAYLOAD: begin
                    if (payload_valid && payload_ready && payload.tlast) begin
                        state     <= RX_IDLE;
                        hdr_ready <= 1'b1; // Next header may be taken right away.
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/ip_tx_deframer.sv
`default_nettype none

module ip_tx_deframer (
    input  logic                       clk_int,
    input  logic                       rst_int,
    input  logic [7:0]                 fifo_dout,
    input  logic                       fifo_empty,
    output logic                       fifo_rd_en,
    output logic                       hdr_valid,
    input  logic                       hdr_ready,
    output ros2_shell_pkg::ip_tx_hdr_t hdr,
    output logic                       payload_valid,
    input  logic                       payload_ready,
    output ros2_shell_pkg::ip_beat_t   payload
);

    import ros2_shell_pkg::*;

    typedef enum logic [1:0] {
        TX_COLLECT,
        TX_HEADER,
        TX_PAYLOAD,
        TX_DONE
    } tx_state_e;

    tx_state_e   state;
    ip_tx_hdr_u  hdr_buf;
    logic [3:0]  byte_cnt;
    logic [15:0] remain;

    assign hdr           = hdr_buf.hdr;
    assign hdr_valid     = (state == TX_HEADER);
    assign payload_valid = (state == TX_PAYLOAD) && !fifo_empty;
    assign payload.tdata = fifo_dout;
    assign payload.tlast = (remain == 16'd1);

    always_comb begin
        case (state)
            TX_COLLECT: fifo_rd_en = !fifo_empty;
            TX_PAYLOAD: fifo_rd_en = !fifo_empty && payload_ready;
            default:    fifo_rd_en = 1'b0;
        endcase
    end

    // Prefix bytes enter at the low end, so the first byte ends up as byte 0.
    always_ff @(posedge clk_int) begin
        if (state == TX_COLLECT && !fifo_empty) begin
            hdr_buf.bytes <= {hdr_buf.bytes[1:TX_HDR_BYTES-1], fifo_dout};
        end
    end

    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            state    <= TX_COLLECT;
            byte_cnt <= '0;
            remain   <= '0;
        end else begin
            case (state)
                TX_COLLECT: begin
                    if (!fifo_empty) begin
                        if (byte_cnt == 4'(TX_HDR_BYTES - 1)) begin
                            state <= TX_HEADER;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                TX_HEADER: begin
                    if (hdr_ready) begin
                        if (hdr_buf.hdr.length > 16'(RX_HDR_BYTES)) begin
                            remain <= hdr_buf.hdr.length - 16'(RX_HDR_BYTES);
                            state  <= TX_PAYLOAD;
                        end else begin
                            state <= TX_DONE; // Header only, no payload follows.
                        end
                    end
                end
                TX_PAYLOAD: begin
                    if (payload_valid && payload_ready) begin
                        remain <= remain - 1'b1;
                        if (payload.tlast) begin
                            state <= TX_DONE;
                        end
                    end
                end
                TX_DONE: begin
                    byte_cnt <= '0;
                    state    <= TX_COLLECT;
                end
                default: begin
                    state <= TX_COLLECT;
                end
            endcase
        end
    end

    a_short_length: assert property (
        @(posedge clk_int) disable iff (rst_int)
        (hdr_valid && hdr_ready) |-> (hdr.length > 16'(RX_HDR_BYTES))
    ) else $warning("tx length %0d leaves no payload", hdr.length);

    a_beat_held: assert property (
        @(posedge clk_int) disable iff (rst_int)
        (payload_valid && !payload_ready) |=> (payload_valid && $stable(payload))
    ) else $error("tx payload beat changed before transfer");

endmodule

`default_nettype wire

//--- verilog/buffer_grant_arbiter.sv
`default_nettype none

module buffer_grant_arbiter (
    input  logic clk_int,
    input  logic rst_int,
    input  logic app_ip_req,
    input  logic app_ip_rel,
    input  logic app_cpu_req,
    input  logic app_cpu_rel,
    output logic app_ip_grant,
    output logic app_cpu_grant,
    input  logic rxbuf_ip_rel,
    input  logic rxbuf_cpu_rel,
    output logic rxbuf_ip_grant,
    output logic rxbuf_cpu_grant
);

    import ros2_shell_pkg::*;

    app_grant_e app_state;
    logic       rxbuf_cpu_owns;

    assign app_ip_grant    = (app_state == GRANT_IP);
    assign app_cpu_grant   = (app_state == GRANT_CPU);
    assign rxbuf_ip_grant  = !rxbuf_cpu_owns;
    assign rxbuf_cpu_grant = rxbuf_cpu_owns;

    // The IP side wins when both sides ask in the same cycle.
    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            app_state <= GRANT_NONE;
        end else begin
            case (app_state)
                GRANT_NONE: begin
                    if (app_ip_req) begin
                        app_state <= GRANT_IP;
                    end else if (app_cpu_req) begin
                        app_state <= GRANT_CPU;
                    end
                end
                GRANT_IP:  if (app_ip_rel) app_state <= GRANT_NONE;
                GRANT_CPU: if (app_cpu_rel) app_state <= GRANT_NONE;
                default:   app_state <= GRANT_NONE;
            endcase
        end
    end

    // The receive buffer always has an owner and changes hands on release.
    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            rxbuf_cpu_owns <= 1'b0;
        end else if (!rxbuf_cpu_owns && rxbuf_ip_rel) begin
            rxbuf_cpu_owns <= 1'b1;
        end else if (rxbuf_cpu_owns && rxbuf_cpu_rel) begin
            rxbuf_cpu_owns <= 1'b0;
        end
    end

    a_app_one_holder: assert property (
        @(posedge clk_int) disable iff (rst_int) !(app_ip_grant && app_cpu_grant)
    ) else $error("app data granted to both sides");

endmodule

`default_nettype wire

//--- verilog/ros2_ip_shell.sv
`default_nettype none

module ros2_ip_shell #(
    parameter int RX_FIFO_DEPTH = 64,
    parameter int TX_FIFO_DEPTH = 64
) (
    input  logic                       clk_int,
    input  logic                       rst_int,

    input  logic                       rx_hdr_valid,
    output logic                       rx_hdr_ready,
    input  ros2_shell_pkg::ip_rx_hdr_t rx_hdr,
    input  logic                       rx_payload_valid,
    output logic                       rx_payload_ready,
    input  ros2_shell_pkg::ip_beat_t   rx_payload,

    output logic                       tx_hdr_valid,
    input  logic                       tx_hdr_ready,
    output ros2_shell_pkg::ip_tx_hdr_t tx_hdr,
    output logic                       tx_payload_valid,
    input  logic                       tx_payload_ready,
    output ros2_shell_pkg::ip_beat_t   tx_payload,

    output logic [7:0]                 core_rx_data,
    output logic                       core_rx_empty,
    input  logic                       core_rx_read,
    input  logic [7:0]                 core_tx_data,
    input  logic                       core_tx_write,
    output logic                       core_tx_full,

    input  logic                       app_ip_req,
    input  logic                       app_ip_rel,
    input  logic                       app_cpu_req,
    input  logic                       app_cpu_rel,
    output logic                       app_ip_grant,
    output logic                       app_cpu_grant,
    input  logic                       rxbuf_ip_rel,
    input  logic                       rxbuf_cpu_rel,
    output logic                       rxbuf_ip_grant,
    output logic                       rxbuf_cpu_grant
);

    wire       rx_fifo_wr_en;
    wire [7:0] rx_fifo_din;
    wire       rx_fifo_full;
    wire       tx_fifo_rd_en;
    wire [7:0] tx_fifo_dout;
    wire       tx_fifo_empty;

    ip_rx_framer u_rx_framer (
        .clk_int       (clk_int),
        .rst_int       (rst_int),
        .hdr_valid     (rx_hdr_valid),
        .hdr_ready     (rx_hdr_ready),
        .hdr           (rx_hdr),
        .payload_valid (rx_payload_valid),
        .payload_ready (rx_payload_ready),
        .payload       (rx_payload),
        .fifo_full     (rx_fifo_full),
        .fifo_wr_en    (rx_fifo_wr_en),
        .fifo_din      (rx_fifo_din)
    );

    byte_fifo #(.DEPTH(RX_FIFO_DEPTH)) rx_fifo (
        .clk_int (clk_int),
        .rst_int (rst_int),
        .wr_en   (rx_fifo_wr_en),
        .din     (rx_fifo_din),
        .rd_en   (core_rx_read),
        .dout    (core_rx_data),
        .full    (rx_fifo_full),
        .empty   (core_rx_empty)
    );

    byte_fifo #(.DEPTH(TX_FIFO_DEPTH)) tx_fifo (
        .clk_int (clk_int),
        .rst_int (rst_int),
        .wr_en   (core_tx_write),
        .din     (core_tx_data),
        .rd_en   (tx_fifo_rd_en),
        .dout    (tx_fifo_dout),
        .full    (core_tx_full),
        .empty   (tx_fifo_empty)
    );

    ip_tx_deframer u_tx_deframer (
        .clk_int       (clk_int),
        .rst_int       (rst_int),
        .fifo_dout     (tx_fifo_dout),
        .fifo_empty    (tx_fifo_empty),
        .fifo_rd_en    (tx_fifo_rd_en),
        .hdr_valid     (tx_hdr_valid),
        .hdr_ready     (tx_hdr_ready),
        .hdr           (tx_hdr),
        .payload_valid (tx_payload_valid),
        .payload_ready (tx_payload_ready),
        .payload       (tx_payload)
    );

    buffer_grant_arbiter u_arbiter (
        .clk_int         (clk_int),
        .rst_int         (rst_int),
        .app_ip_req      (app_ip_req),
        .app_ip_rel      (app_ip_rel),
        .app_cpu_req     (app_cpu_req),
        .app_cpu_rel     (app_cpu_rel),
        .app_ip_grant    (app_ip_grant),
        .app_cpu_grant   (app_cpu_grant),
        .rxbuf_ip_rel    (rxbuf_ip_rel),
        .rxbuf_cpu_rel   (rxbuf_cpu_rel),
        .rxbuf_ip_grant  (rxbuf_ip_grant),
        .rxbuf_cpu_grant (rxbuf_cpu_grant)
    );

endmodule

`default_nettype wire

//--- tb/tb_ros2_ip_shell.sv
`default_nettype none

module tb_ros2_ip_shell;

    timeunit 1ns;
    timeprecision 100ps;

    import ros2_shell_pkg::*;

    localparam int MAX_REC = 32;

    logic       clk_int;
    logic       rst_int;
    logic       rx_hdr_valid;
    logic       rx_hdr_ready;
    ip_rx_hdr_t rx_hdr;
    logic       rx_payload_valid;
    logic       rx_payload_ready;
    ip_beat_t   rx_payload;
    logic       tx_hdr_valid;
    logic       tx_hdr_ready;
    ip_tx_hdr_t tx_hdr;
    logic       tx_payload_valid;
    logic       tx_payload_ready;
    ip_beat_t   tx_payload;
    logic [7:0] core_rx_data;
    logic       core_rx_empty;
    logic       core_rx_read;
    logic [7:0] core_tx_data;
    logic       core_tx_write;
    logic       core_tx_full;
    logic       app_ip_req;
    logic       app_ip_rel;
    logic       app_cpu_req;
    logic       app_cpu_rel;
    logic       app_ip_grant;
    logic       app_cpu_grant;
    logic       rxbuf_ip_rel;
    logic       rxbuf_cpu_rel;
    logic       rxbuf_ip_grant;
    logic       rxbuf_cpu_grant;

    logic [31:0] rec [0:MAX_REC-1][0:15];
    logic [7:0]  rec_kind [0:MAX_REC-1];
    int          n_rec = 0;
    logic        records_loaded = 1'b0;
    int          mismatches = 0;
    int          failures = 0;
    int          rx_stalls = 0;
    int          tx_stalls = 0;
    logic [31:0] rng_state = 32'h7e50_3a61;

    ros2_ip_shell UUT (.*);

    initial begin
        clk_int = 1'b0;
        forever #10 clk_int = ~clk_int;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int field_count(input int kind);
        if (kind == "R") return 16;
        if (kind == "T") return 9;
        return 10;
    endfunction

    // Header fields laid out most significant first, as they appear on the wire.
    function automatic logic [159:0] rx_header_bits(input int idx);
        return {rec[idx][0][3:0], rec[idx][1][3:0], rec[idx][2][5:0], rec[idx][3][1:0],
                rec[idx][4][15:0], rec[idx][5][15:0], rec[idx][6][2:0], rec[idx][7][12:0],
                rec[idx][8][7:0], rec[idx][9][7:0], rec[idx][10][15:0], rec[idx][11],
                rec[idx][12]};
    endfunction

    function automatic logic [103:0] tx_prefix_bits(input int idx);
        return {rec[idx][0][5:0], rec[idx][1][1:0], rec[idx][2][15:0], rec[idx][3][7:0],
                rec[idx][4][7:0], rec[idx][5], rec[idx][6]};
    endfunction

    function automatic int tx_payload_len(input int idx);
        int len;
        len = int'(rec[idx][2][15:0]);
        return (len > 20) ? len - 20 : 0; // IP length counts the 20 header bytes.
    endfunction

    function automatic logic [7:0] payload_byte(input logic [31:0] first,
                                                input logic [31:0] step, input int k);
        return 8'(first + k * step);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic finish_run();
        $display("Check summary: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    task automatic load_records();
        int fd;
        int c;
        int k;
        int r;
        fd = $fopen("tb/tb_ros2_ip_shell_input.txt", "r");
        assert (fd != 0) else begin
            failures++;
            $display("Could not open the stimulus file tb/tb_ros2_ip_shell_input.txt");
        end
        if (fd != 0) begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == "#") begin
                    while (c != "\n" && c != -1) c = $fgetc(fd); // Skip a comment line.
                end else if (c == "R" || c == "T" || c == "A") begin
                    rec_kind[n_rec] = 8'(c);
                    for (k = 0; k < field_count(c); k++) begin
                        r = $fscanf(fd, "%h", rec[n_rec][k]);
                        assert (r == 1) else begin
                            failures++;
                            $display("Stimulus record %0d is missing field %0d", n_rec, k);
                        end
                    end
                    n_rec++;
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
        records_loaded = 1'b1;
    endtask

    task automatic send_rx_packet(input int idx);
        int   n;
        int   i;
        logic hs;
        n = int'(rec[idx][13]);
        rx_hdr = rx_header_bits(idx);
        rx_hdr_valid = 1'b1;
        hs = 1'b0;
        while (!hs) begin
            hs = rx_hdr_ready;
            @(posedge clk_int);
            #2;
        end
        rx_hdr_valid = 1'b0;
        for (i = 0; i < n; i++) begin
            rx_payload.tdata = payload_byte(rec[idx][14], rec[idx][15], i);
            rx_payload.tlast = (i == n - 1);
            rx_payload_valid = 1'b1;
            hs = 1'b0;
            while (!hs) begin
                hs = rx_payload_ready;
                if (!hs && i > 0) rx_stalls++; // Only stalls from a full FIFO count.
                @(posedge clk_int);
                #2;
            end
        end
        rx_payload_valid = 1'b0;
    endtask

    task automatic read_rx_packet(input int idx);
        logic [159:0] hv;
        logic [7:0]   exp;
        int           total;
        int           i;
        int           gap;
        hv = rx_header_bits(idx);
        total = 20 + int'(rec[idx][13]);
        for (i = 0; i < total; i++) begin
            gap = int'(next_random() & 32'h7);
            repeat (gap) begin
                @(posedge clk_int);
                #2;
            end
            while (core_rx_empty) begin
                @(posedge clk_int);
                #2;
            end
            if (i < 20) begin
                exp = hv[159 - 8 * i -: 8];
            end else begin
                exp = payload_byte(rec[idx][14], rec[idx][15], i - 20);
            end
            check_value("core_rx_data", core_rx_data, exp);
            core_rx_read = 1'b1;
            @(posedge clk_int);
            #2;
            core_rx_read = 1'b0;
        end
    endtask

    task automatic write_tx_packet(input int idx);
        logic [103:0] pv;
        int           total;
        int           i;
        int           gap;
        pv = tx_prefix_bits(idx);
        total = 13 + tx_payload_len(idx);
        for (i = 0; i < total; i++) begin
            gap = int'(next_random() & 32'h3);
            repeat (gap) begin
                @(posedge clk_int);
                #2;
            end
            while (core_tx_full) begin
                @(posedge clk_int);
                #2;
            end
            if (i < 13) begin
                core_tx_data = pv[103 - 8 * i -: 8];
            end else begin
                core_tx_data = payload_byte(rec[idx][7], rec[idx][8], i - 13);
            end
            core_tx_write = 1'b1;
            @(posedge clk_int);
            #2;
            core_tx_write = 1'b0;
        end
    endtask

    task automatic receive_tx_packet(input int idx);
        logic [31:0] rnd;
        logic        got;
        int          n;
        int          i;
        n = tx_payload_len(idx);
        got = 1'b0;
        while (!got) begin
            rnd = next_random();
            tx_hdr_ready = rnd[0];
            assert (!tx_payload_valid) else begin
                failures++;
                $display("A tx payload beat appeared outside a packet at %0t", $time);
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                got = 1'b1;
                check_value("tx_hdr.dscp", tx_hdr.dscp, rec[idx][0][5:0]);
                check_value("tx_hdr.ecn", tx_hdr.ecn, rec[idx][1][1:0]);
                check_value("tx_hdr.length", tx_hdr.length, rec[idx][2][15:0]);
                check_value("tx_hdr.ttl", tx_hdr.ttl, rec[idx][3][7:0]);
                check_value("tx_hdr.protocol", tx_hdr.protocol, rec[idx][4][7:0]);
                check_value("tx_hdr.source_ip", tx_hdr.source_ip, rec[idx][5]);
                check_value("tx_hdr.dest_ip", tx_hdr.dest_ip, rec[idx][6]);
            end
            @(posedge clk_int);
            #2;
        end
        tx_hdr_ready = 1'b0;
        i = 0;
        while (i < n) begin
            rnd = next_random();
            tx_payload_ready = rnd[0] | rnd[1];
            if (tx_payload_valid && tx_payload_ready) begin
                check_value("tx_payload.tdata", tx_payload.tdata,
                            payload_byte(rec[idx][7], rec[idx][8], i));
                check_value("tx_payload.tlast", tx_payload.tlast, (i == n - 1));
                i++;
            end else if (tx_payload_valid) begin
                tx_stalls++;
            end
            @(posedge clk_int);
            #2;
        end
        tx_payload_ready = 1'b0;
    endtask

    task automatic run_arbiter_step(input int idx);
        app_ip_req    = rec[idx][0][0];
        app_ip_rel    = rec[idx][1][0];
        app_cpu_req   = rec[idx][2][0];
        app_cpu_rel   = rec[idx][3][0];
        rxbuf_ip_rel  = rec[idx][4][0];
        rxbuf_cpu_rel = rec[idx][5][0];
        @(posedge clk_int);
        #2;
        check_value("app_ip_grant", app_ip_grant, rec[idx][6]);
        check_value("app_cpu_grant", app_cpu_grant, rec[idx][7]);
        check_value("rxbuf_ip_grant", rxbuf_ip_grant, rec[idx][8]);
        check_value("rxbuf_cpu_grant", rxbuf_cpu_grant, rec[idx][9]);
        {app_ip_req, app_ip_rel, app_cpu_req, app_cpu_rel} = 4'b0000;
        {rxbuf_ip_rel, rxbuf_cpu_rel} = 2'b00;
    endtask

    initial begin : watchdog
        wait (records_loaded);
        repeat (n_rec * 200 + 1000) @(posedge clk_int);
        failures++;
        $display("Timeout: the tests did not finish within %0d clock cycles", n_rec * 200 + 1000);
        finish_run();
    end

    initial begin : main
        int r;
        rst_int          = 1'b1;
        rx_hdr_valid     = 1'b0;
        rx_hdr           = '0;
        rx_payload_valid = 1'b0;
        rx_payload       = '0;
        tx_hdr_ready     = 1'b0;
        tx_payload_ready = 1'b0;
        core_rx_read     = 1'b0;
        core_tx_data     = 8'h00;
        core_tx_write    = 1'b0;
        {app_ip_req, app_ip_rel, app_cpu_req, app_cpu_rel} = 4'b0000;
        {rxbuf_ip_rel, rxbuf_cpu_rel} = 2'b00;
        load_records();
        repeat (8) @(posedge clk_int);
        #2;
        rst_int = 1'b0;
        check_value("rx_hdr_ready", rx_hdr_ready, 1'b0);
        check_value("rx_payload_ready", rx_payload_ready, 1'b0);
        check_value("tx_hdr_valid", tx_hdr_valid, 1'b0);
        check_value("tx_payload_valid", tx_payload_valid, 1'b0);
        check_value("app_ip_grant", app_ip_grant, 1'b0);
        check_value("app_cpu_grant", app_cpu_grant, 1'b0);
        check_value("rxbuf_ip_grant", rxbuf_ip_grant, 1'b1);
        check_value("rxbuf_cpu_grant", rxbuf_cpu_grant, 1'b0);
        check_value("core_rx_empty", core_rx_empty, 1'b1);
        check_value("core_tx_full", core_tx_full, 1'b0);
        @(posedge clk_int);
        #2;
        check_value("rx_hdr_ready", rx_hdr_ready, 1'b1); // Idle framer opens up after reset.
        for (r = 0; r < n_rec; r++) begin
            case (rec_kind[r])
                "R": begin
                    fork
                        send_rx_packet(r);
                        read_rx_packet(r);
                    join
                    check_value("core_rx_empty", core_rx_empty, 1'b1);
                end
                "T": begin
                    fork
                        write_tx_packet(r);
                        receive_tx_packet(r);
                    join
                end
                default: run_arbiter_step(r);
            endcase
        end
        repeat (4) begin
            @(posedge clk_int);
            #2;
        end
        check_value("core_rx_empty", core_rx_empty, 1'b1);
        check_value("tx_hdr_valid", tx_hdr_valid, 1'b0);
        check_value("tx_payload_valid", tx_payload_valid, 1'b0);
        if (n_rec > 0) begin
            assert (rx_stalls > 0) else begin
                failures++;
                $display("The rx FIFO never filled, so rx payload back-pressure was not seen");
            end
            assert (tx_stalls > 0) else begin
                failures++;
                $display("No tx payload beat was ever held by a low tx_payload_ready");
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- tb/tb_ros2_ip_shell_input.txt
# All fields hex. R: version ihl dscp ecn length id flags frag ttl proto csum src dst count first step
# T: dscp ecn length ttl proto src dst first step. A: ip_req ip_rel cpu_req cpu_rel rxip_rel rxcpu_rel
# then the expected app_ip_grant app_cpu_grant rxbuf_ip_grant rxbuf_cpu_grant.
R 4 5 00 0 0030 1c46 2 0000 40 11 b1e6 c0a80001 c0a800c7 1c 01 01
R 4 5 2e 1 0074 abcd 0 1fff 01 11 0000 0a0a0a0a 0b0b0b0b 60 f0 07
T 2e 1 0034 40 11 c0a80010 c0a80001 10 03
T 00 0 0015 ff 11 0a000001 0a000002 a5 01
A 0 0 0 0 0 0 0 0 1 0
A 1 0 1 0 0 0 1 0 1 0
A 0 0 0 1 0 0 1 0 1 0
A 0 1 0 0 0 0 0 0 1 0
A 0 0 1 0 0 0 0 1 1 0
A 1 1 0 0 0 0 0 1 1 0
A 0 0 0 1 0 0 0 0 1 0
A 0 0 0 0 0 1 0 0 1 0
A 0 0 0 0 1 0 0 0 0 1
A 0 0 0 0 1 0 0 0 0 1
A 0 0 0 0 0 1 0 0 1 0
T 3f 3 0014 80 06 ac100001 ac100002 00 00
R 4 5 3f 3 0015 0001 7 0000 ff 06 ffff 00000000 ffffffff 01 5a 00
T 01 2 0050 20 11 c0a80101 c0a80102 7f fd

//--- flist.f
verilog/ros2_shell_pkg.sv
verilog/byte_fifo.sv
verilog/ip_rx_framer.sv
verilog/ip_tx_deframer.sv
verilog/buffer_grant_arbiter.sv
verilog/ros2_ip_shell.sv
tb/tb_ros2_ip_shell.sv

//--- Bender.yml
package:
  name: ros2_ip_shell

sources:
  - verilog/ros2_shell_pkg.sv
  - verilog/byte_fifo.sv
  - verilog/ip_rx_framer.sv
  - verilog/ip_tx_deframer.sv
  - verilog/buffer_grant_arbiter.sv
  - verilog/ros2_ip_shell.sv
  - target: simulation
    files:
      - tb/tb_ros2_ip_shell.sv
